// ==== source/gw_config.svh ====
`ifndef GW_CONFIG_SVH
`define GW_CONFIG_SVH

////////////////////
// Bus widths
`define GW_ADDR_WIDTH 20
`define GW_DATA_WIDTH 32

////////////////////
// Address map
// Everything below the DRAM base belongs to the host block
`define GW_DRAM_BASE_ADDR   20'h80000
`define GW_HOST_FINISH_ADDR 20'h00100
`define GW_HOST_STATUS_ADDR 20'h00104

////////////////////
// Memory model and host
`define GW_MEM_WORDS   256
`define GW_MEM_LATENCY 3
`define GW_NUM_CORE    4

`endif

// ==== source/gw_pkg.sv ====
`include "gw_config.svh"

package gw_pkg;

  // Byte address and data word
  typedef logic [`GW_ADDR_WIDTH-1:0] gw_addr_t;
  typedef logic [`GW_DATA_WIDTH-1:0] gw_data_t;

  // One program-finish bit per core
  typedef logic [`GW_NUM_CORE-1:0] gw_finish_t;

  typedef enum logic
  {
    GW_OP_READ  = 1'b0,
    GW_OP_WRITE = 1'b1
  } gw_op_e;

  typedef struct packed
  {
    gw_op_e   op;
    gw_addr_t addr;
    gw_data_t data;
  } gw_cmd_s;

  // Address echoed back with the response
  typedef struct packed
  {
    gw_op_e   op;
    gw_addr_t addr;
    gw_data_t data;
  } gw_resp_s;

  typedef enum logic [1:0]
  {
    DISP_IDLE = 2'd0,
    DISP_HOST = 2'd1,
    DISP_MEM  = 2'd2
  } gw_disp_state_e;

endpackage

// ==== source/gw_cmd_dispatch.sv ====
`timescale 1ns/1ps

`include "gw_config.svh"

module gw_cmd_dispatch
(
  input  logic            clk_i,
  input  logic            arst_n_i,

  input  logic            cmd_valid_i,
  input  gw_pkg::gw_cmd_s cmd_i,
  output logic            cmd_ready_o,

  output logic            host_cmd_valid_o,
  output gw_pkg::gw_cmd_s host_cmd_o,
  input  logic            host_cmd_ready_i,

  output logic            mem_cmd_valid_o,
  output gw_pkg::gw_cmd_s mem_cmd_o,
  input  logic            mem_cmd_ready_i,

  input  logic            resp_done_i
);

  import gw_pkg::*;

  gw_disp_state_e state_q;
  gw_disp_state_e state_d;
  logic           idle;
  logic           is_host;
  logic           accept;

  ////////////////////
  // Address decode and steering

  assign idle    = (state_q == DISP_IDLE);
  assign is_host = (cmd_i.addr < `GW_DRAM_BASE_ADDR);

  // Valid goes only to the selected target
  assign host_cmd_o = cmd_i;
  assign mem_cmd_o  = cmd_i;

  assign host_cmd_valid_o = cmd_valid_i & idle & is_host;
  assign mem_cmd_valid_o  = cmd_valid_i & idle & ~is_host;

  assign cmd_ready_o = idle & (is_host ? host_cmd_ready_i : mem_cmd_ready_i);
  assign accept      = cmd_valid_i & cmd_ready_o;

  ////////////////////
  // Outstanding request FSM

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      DISP_IDLE:
      begin
        if (accept)
        begin
          state_d = is_host ? DISP_HOST : DISP_MEM;
        end
      end
      DISP_HOST,
      DISP_MEM:
      begin
        if (resp_done_i)
        begin
          state_d = DISP_IDLE;
        end
      end
      default: state_d = DISP_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q <= DISP_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  a_accept_only_idle : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    accept |=> !cmd_ready_o);

  // The merger never completes a request nobody issued
  a_done_only_busy : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    resp_done_i |-> (state_q != DISP_IDLE));

endmodule

// ==== source/gw_host_mmio.sv ====
`timescale 1ns/1ps

`include "gw_config.svh"

module gw_host_mmio
(
  input  logic               clk_i,
  input  logic               arst_n_i,

  input  logic               cmd_valid_i,
  input  gw_pkg::gw_cmd_s    cmd_i,
  output logic               cmd_ready_o,

  output logic               resp_valid_o,
  output gw_pkg::gw_resp_s   resp_o,
  input  logic               resp_ready_i,

  output gw_pkg::gw_finish_t finish_o
);

  import gw_pkg::*;

  localparam int FIN_IDX_W = (`GW_NUM_CORE > 1) ? $clog2(`GW_NUM_CORE) : 1;

  logic       resp_valid_q;
  gw_resp_s   resp_q;
  gw_finish_t finish_q;
  logic       accept;
  logic       is_write;
  gw_data_t   rd_data;

  assign cmd_ready_o = ~resp_valid_q;
  assign accept      = cmd_valid_i & cmd_ready_o;
  assign is_write    = (cmd_i.op == GW_OP_WRITE);

  // Only the status register reads back something
  assign rd_data = (cmd_i.addr == `GW_HOST_STATUS_ADDR) ? gw_data_t'(finish_q) : '0;

  ////////////////////
  // Finish bits and response valid

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      finish_q     <= '0;
      resp_valid_q <= 1'b0;
    end
    else
    begin
      if (accept && is_write && (cmd_i.addr == `GW_HOST_FINISH_ADDR))
      begin
        finish_q[cmd_i.data[FIN_IDX_W-1:0]] <= 1'b1;
      end
      if (accept)
      begin
        resp_valid_q <= 1'b1;
      end
      else if (resp_ready_i)
      begin
        resp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_q.op   <= cmd_i.op;
      resp_q.addr <= cmd_i.addr;
      resp_q.data <= is_write ? '0 : rd_data;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;
  assign finish_o     = finish_q;

endmodule

// ==== source/gw_mem_model.sv ====
`timescale 1ns/1ps

`include "gw_config.svh"

module gw_mem_model
(
  input  logic             clk_i,
  input  logic             arst_n_i,

  input  logic             cmd_valid_i,
  input  gw_pkg::gw_cmd_s  cmd_i,
  output logic             cmd_ready_o,

  output logic             resp_valid_o,
  output gw_pkg::gw_resp_s resp_o,
  input  logic             resp_ready_i
);

  import gw_pkg::*;

  localparam int IDX_W = $clog2(`GW_MEM_WORDS);
  localparam int CNT_W = $clog2(`GW_MEM_LATENCY + 1);

  gw_data_t                 mem_q [`GW_MEM_WORDS];
  logic [`GW_MEM_WORDS-1:0] written_q;
  logic                     busy_q;
  logic [CNT_W-1:0]         cnt_q;
  gw_resp_s                 resp_q;
  gw_addr_t                 offset;
  logic [IDX_W-1:0]         idx;
  logic                     accept;
  logic                     is_write;
  gw_data_t                 rd_word;

  ////////////////////
  // Word index wraps over the array
  assign offset = cmd_i.addr - `GW_DRAM_BASE_ADDR;
  assign idx    = offset[IDX_W+1:2];

  assign cmd_ready_o = ~busy_q;
  assign accept      = cmd_valid_i & cmd_ready_o;
  assign is_write    = (cmd_i.op == GW_OP_WRITE);

  // Untouched words read as zero
  assign rd_word = written_q[idx] ? mem_q[idx] : '0;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      written_q <= '0;
      busy_q    <= 1'b0;
      cnt_q     <= '0;
    end
    else
    begin
      if (accept)
      begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(`GW_MEM_LATENCY - 1);
        if (is_write)
        begin
          written_q[idx] <= 1'b1;
        end
      end
      else if (busy_q && (cnt_q != '0))
      begin
        cnt_q <= cnt_q - 1'b1;
      end
      else if (resp_valid_o && resp_ready_i)
      begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      if (is_write)
      begin
        mem_q[idx] <= cmd_i.data;
      end
      resp_q.op   <= cmd_i.op;
      resp_q.addr <= cmd_i.addr;
      resp_q.data <= is_write ? '0 : rd_word;
    end
  end

  assign resp_valid_o = busy_q & (cnt_q == '0);
  assign resp_o       = resp_q;

  // Dispatcher decode must keep host traffic out of here
  a_dram_addr : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    accept |-> (cmd_i.addr >= `GW_DRAM_BASE_ADDR));

endmodule

// ==== source/gw_resp_merge.sv ====
`timescale 1ns/1ps

module gw_resp_merge
(
  input  logic             clk_i,
  input  logic             arst_n_i,

  input  logic             host_resp_valid_i,
  input  gw_pkg::gw_resp_s host_resp_i,
  output logic             host_resp_ready_o,

  input  logic             mem_resp_valid_i,
  input  gw_pkg::gw_resp_s mem_resp_i,
  output logic             mem_resp_ready_o,

  output logic             resp_valid_o,
  output gw_pkg::gw_resp_s resp_o,
  input  logic             resp_ready_i,

  output logic             resp_done_o
);

  import gw_pkg::*;

  logic     valid_q;
  gw_resp_s resp_q;
  logic     load;

  // Host wins when both offer
  assign host_resp_ready_o = ~valid_q;
  assign mem_resp_ready_o  = ~valid_q & ~host_resp_valid_i;
  assign load              = ~valid_q & (host_resp_valid_i | mem_resp_valid_i);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      valid_q <= 1'b0;
    end
    else if (load)
    begin
      valid_q <= 1'b1;
    end
    else if (resp_ready_i)
    begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      resp_q <= host_resp_valid_i ? host_resp_i : mem_resp_i;
    end
  end

  assign resp_valid_o = valid_q;
  assign resp_o       = resp_q;
  assign resp_done_o  = valid_q & resp_ready_i;

  a_hold_stable : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_o)));

  // One request in flight, so only one source can answer
  a_one_source : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(host_resp_valid_i && mem_resp_valid_i));

endmodule

// ==== source/gw_mem_gateway.sv ====
`timescale 1ns/1ps

module gw_mem_gateway
(
  input  logic               clk_i,
  input  logic               arst_n_i,

  input  logic               cmd_valid_i,
  input  gw_pkg::gw_cmd_s    cmd_i,
  output logic               cmd_ready_o,

  output logic               resp_valid_o,
  output gw_pkg::gw_resp_s   resp_o,
  input  logic               resp_ready_i,

  output gw_pkg::gw_finish_t finish_o
);

  import gw_pkg::*;

  logic     host_cmd_valid;
  gw_cmd_s  host_cmd;
  logic     host_cmd_ready;
  logic     mem_cmd_valid;
  gw_cmd_s  mem_cmd;
  logic     mem_cmd_ready;
  logic     host_resp_valid;
  gw_resp_s host_resp;
  logic     host_resp_ready;
  logic     mem_resp_valid;
  gw_resp_s mem_resp;
  logic     mem_resp_ready;
  logic     resp_done;

  ////////////////////
  // Input side

  gw_cmd_dispatch cmd_dispatch_i
  (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_i            (cmd_i),
    .cmd_ready_o      (cmd_ready_o),
    .host_cmd_valid_o (host_cmd_valid),
    .host_cmd_o       (host_cmd),
    .host_cmd_ready_i (host_cmd_ready),
    .mem_cmd_valid_o  (mem_cmd_valid),
    .mem_cmd_o        (mem_cmd),
    .mem_cmd_ready_i  (mem_cmd_ready),
    .resp_done_i      (resp_done)
  );

  ////////////////////
  // Targets

  gw_host_mmio host_mmio_i
  (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_valid_i  (host_cmd_valid),
    .cmd_i        (host_cmd),
    .cmd_ready_o  (host_cmd_ready),
    .resp_valid_o (host_resp_valid),
    .resp_o       (host_resp),
    .resp_ready_i (host_resp_ready),
    .finish_o     (finish_o)
  );

  gw_mem_model mem_model_i
  (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .cmd_valid_i  (mem_cmd_valid),
    .cmd_i        (mem_cmd),
    .cmd_ready_o  (mem_cmd_ready),
    .resp_valid_o (mem_resp_valid),
    .resp_o       (mem_resp),
    .resp_ready_i (mem_resp_ready)
  );

  ////////////////////
  // Output side

  gw_resp_merge resp_merge_i
  (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .host_resp_valid_i (host_resp_valid),
    .host_resp_i       (host_resp),
    .host_resp_ready_o (host_resp_ready),
    .mem_resp_valid_i  (mem_resp_valid),
    .mem_resp_i        (mem_resp),
    .mem_resp_ready_o  (mem_resp_ready),
    .resp_valid_o      (resp_valid_o),
    .resp_o            (resp_o),
    .resp_ready_i      (resp_ready_i),
    .resp_done_o       (resp_done)
  );

endmodule

// ==== bench/gw_checker.sv ====
`timescale 1ns/1ps

module gw_checker
(
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               cmd_valid_i,
  input  logic               cmd_ready_i,
  input  logic               resp_valid_i,
  input  gw_pkg::gw_resp_s   resp_i,
  input  logic               resp_ready_i,
  input  gw_pkg::gw_finish_t finish_i,
  output int                 resp_count_o,
  output int                 error_count_o
);

  import gw_pkg::*;

  localparam int MAX_LINES    = 64;
  localparam int COLS         = 5;
  localparam int RESP_TIMEOUT = 200;

  logic [31:0] golden_q [MAX_LINES*COLS];
  int          num_vec       = 0;
  int          resp_count    = 0;
  int          error_count   = 0;
  int          wait_cycles   = 0;
  logic        outstanding   = 1'b0;
  logic        reset_checked = 1'b0;
  logic        held          = 1'b0;
  gw_resp_s    held_resp     = '0;

  initial
  begin
    for (int i = 0; i < MAX_LINES*COLS; i++)
    begin
      golden_q[i] = 32'hF000_0000 | 32'(i);
    end
    $readmemh("bench/gw_golden.txt", golden_q);
    // Fill words past the last line hold no valid op
    while ((num_vec < MAX_LINES) && (golden_q[num_vec*COLS] <= 32'd1))
    begin
      num_vec++;
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_response();
    int base;
    base = resp_count * COLS;
    if (resp_count >= num_vec)
    begin
      $display("Response %0d arrived with no command left to answer", resp_count);
      error_count++;
    end
    else
    begin
      check_value("resp_o.op", 64'(resp_i.op), 64'(golden_q[base]));
      check_value("resp_o.addr", 64'(resp_i.addr), 64'(golden_q[base+1]));
      check_value("resp_o.data", 64'(resp_i.data), 64'(golden_q[base+3]));
      check_value("finish_o", 64'(finish_i), 64'(golden_q[base+4]));
    end
    resp_count++;
  endtask

  ////////////////////
  // Sampled mid-cycle before the edge that transfers

  always @(negedge clk_i)
  begin
    if (arst_n_i)
    begin
      if (!reset_checked)
      begin
        check_value("resp_valid_o", 64'(resp_valid_i), 64'h0);
        check_value("cmd_ready_o", 64'(cmd_ready_i), 64'h1);
        check_value("finish_o", 64'(finish_i), 64'h0);
        reset_checked = 1'b1;
      end
      // Held response under back-pressure
      if (held)
      begin
        check_value("resp_valid_o", 64'(resp_valid_i), 64'h1);
        check_value("resp_o", 64'(resp_i), 64'(held_resp));
      end
      held      = resp_valid_i && !resp_ready_i;
      held_resp = resp_i;
      if (outstanding && cmd_ready_i)
      begin
        check_value("cmd_ready_o", 64'(cmd_ready_i), 64'h0);
      end
      if (cmd_valid_i && cmd_ready_i)
      begin
        outstanding = 1'b1;
        wait_cycles = 0;
      end
      if (resp_valid_i && resp_ready_i)
      begin
        if (!outstanding)
        begin
          $display("Response %0d arrived without a command in flight", resp_count);
          error_count++;
        end
        compare_response();
        outstanding = 1'b0;
      end
      else if (outstanding)
      begin
        wait_cycles++;
        if (wait_cycles == RESP_TIMEOUT)
        begin
          $display("No response within %0d cycles of command %0d", RESP_TIMEOUT, resp_count);
          error_count++;
        end
      end
    end
  end

  assign resp_count_o  = resp_count;
  assign error_count_o = error_count;

endmodule

// ==== bench/tb_gw_mem_gateway.sv ====
`timescale 1ns/1ps

module tb_gw_mem_gateway;

  import gw_pkg::*;

  localparam int MAX_LINES     = 64;
  localparam int COLS          = 5;
  localparam int READY_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT = 200;
  localparam int IDLE_CYCLES   = 10;

  logic        clk        = 1'b0;
  logic        arst_n     = 1'b0;
  logic        cmd_valid  = 1'b0;
  gw_cmd_s     cmd        = '0;
  logic        cmd_ready;
  logic        resp_valid;
  gw_resp_s    resp;
  logic        resp_ready = 1'b0;
  gw_finish_t  finish;
  int          resp_count;
  int          check_errors;
  logic [31:0] golden_q [MAX_LINES*COLS];
  int          num_vec    = 0;

  always #20 clk = ~clk;

  gw_mem_gateway dut_i
  (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .cmd_valid_i  (cmd_valid),
    .cmd_i        (cmd),
    .cmd_ready_o  (cmd_ready),
    .resp_valid_o (resp_valid),
    .resp_o       (resp),
    .resp_ready_i (resp_ready),
    .finish_o     (finish)
  );

  gw_checker gw_checker
  (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .cmd_valid_i   (cmd_valid),
    .cmd_ready_i   (cmd_ready),
    .resp_valid_i  (resp_valid),
    .resp_i        (resp),
    .resp_ready_i  (resp_ready),
    .finish_i      (finish),
    .resp_count_o  (resp_count),
    .error_count_o (check_errors)
  );

  // Back-pressure about a third of the cycles
  always @(posedge clk)
  begin
    #2;
    resp_ready = ($urandom_range(2, 0) != 0);
  end

  ////////////////////
  // Command driver

  task automatic send_command(input int line, output logic ok);
    int      base;
    int      wait_cycles;
    gw_cmd_s next;
    base        = line * COLS;
    next.op     = gw_op_e'(golden_q[base][0]);
    next.addr   = gw_addr_t'(golden_q[base+1]);
    next.data   = gw_data_t'(golden_q[base+2]);
    cmd         = next;
    cmd_valid   = 1'b1;
    ok          = 1'b0;
    wait_cycles = 0;
    while (!ok && (wait_cycles < READY_TIMEOUT))
    begin
      @(negedge clk);
      ok = cmd_ready;
      @(posedge clk);
      #2;
      wait_cycles++;
    end
    if (!ok)
    begin
      $display("Timeout: command %0d not accepted within %0d cycles", line, READY_TIMEOUT);
    end
  endtask

  task automatic wait_for_responses(output logic ok);
    int wait_cycles;
    wait_cycles = 0;
    while ((resp_count < num_vec) && (wait_cycles < DRAIN_TIMEOUT))
    begin
      @(posedge clk);
      wait_cycles++;
    end
    ok = (resp_count >= num_vec);
    if (!ok)
    begin
      $display("Timeout: %0d of %0d responses arrived", resp_count, num_vec);
    end
    // A duplicate response in this quiet window would still be counted
    wait_cycles = 0;
    while (wait_cycles < IDLE_CYCLES)
    begin
      @(posedge clk);
      wait_cycles++;
    end
  endtask

  initial
  begin
    logic ok;
    int   other_errors;
    int   total;
    other_errors = 0;
    ok           = 1'b1;
    void'($urandom(32'h2775));
    for (int i = 0; i < MAX_LINES*COLS; i++)
    begin
      golden_q[i] = 32'hF000_0000 | 32'(i);
    end
    $readmemh("bench/gw_golden.txt", golden_q);
    while ((num_vec < MAX_LINES) && (golden_q[num_vec*COLS] <= 32'd1))
    begin
      num_vec++;
    end

    repeat (16) @(posedge clk);
    #2;
    arst_n = 1'b1;

    for (int i = 0; (i < num_vec) && ok; i++)
    begin
      send_command(i, ok);
    end
    cmd_valid = 1'b0;
    if (!ok)
    begin
      other_errors++;
    end
    else
    begin
      wait_for_responses(ok);
      if (!ok)
      begin
        other_errors++;
      end
    end
    if (resp_count != num_vec)
    begin
      $display("Got %0d responses for %0d commands", resp_count, num_vec);
      other_errors++;
    end

    total = check_errors + other_errors;
    $display("Summary: %0d check errors, %0d other errors, %0d of %0d responses",
             check_errors, other_errors, resp_count, num_vec);
    if (total == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== bench/gw_golden.txt ====
// op addr data exp_data exp_finish, all hex, op 0 is a read and 1 a write
// exp_data is the response data, exp_finish is finish_o when that response is taken
0 80000 00000000 00000000 0
1 80000 deadbeef 00000000 0
1 80004 12345678 00000000 0
1 80400 a5a5a5a5 00000000 0
0 80000 00000000 a5a5a5a5 0
0 80004 00000000 12345678 0
1 803fc 0badf00d 00000000 0
0 803fc 00000000 0badf00d 0
0 80008 00000000 00000000 0
0 00104 00000000 00000000 0
1 00100 00000002 00000000 4
1 00100 00000000 00000000 5
0 00104 00000000 00000005 5
1 00200 00000003 00000000 5
0 00200 00000000 00000000 5
0 00100 00000000 00000000 5
1 00100 00000007 00000000 d
1 00104 00000001 00000000 d
0 00104 00000000 0000000d d
1 80004 ffffffff 00000000 d
0 80004 00000000 ffffffff d
0 80400 00000000 a5a5a5a5 d

// ==== files.f ====
+incdir+source
source/gw_pkg.sv
source/gw_cmd_dispatch.sv
source/gw_host_mmio.sv
source/gw_mem_model.sv
source/gw_resp_merge.sv
source/gw_mem_gateway.sv
bench/gw_checker.sv
bench/tb_gw_mem_gateway.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= tb_gw_mem_gateway
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Errors found
PASS_MSG  := No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
